// ==== Makefile ====
# Verilator simulation of the MLP accelerator testbench

sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module mlp_tb \
		--Mdir obj_dir -o mlp_sim
	./obj_dir/mlp_sim | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== compile.f ====
+incdir+logic
logic/mlp_pkg.sv
logic/mvm_engine.sv
logic/mvm_crossbar.sv
logic/mlp_controller.sv
logic/mlp_top.sv
tests/mlp_tb.sv

// ==== logic/mlp_controller.sv ====
`timescale 1ns/10ps
`include "mlp_macros.svh"

module mlp_controller
    import mlp_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [3:0]             address,
    input  logic                   chipselect,
    input  logic                   read,
    input  logic                   write,
    input  logic [31:0]            writedata,
    output logic [31:0]            readdata,
    output logic [9:0]             led_out,
    output logic                   req_valid,
    output logic [`MLP_DATA_W-1:0] req_data,
    output logic [`MLP_DEST_W-1:0] req_dest,
    output pkt_type_e              req_type,
    input  logic                   req_ready,
    input  logic                   out_valid,
    input  logic [`MLP_DATA_W-1:0] out_data,
    input  logic [`MLP_DEST_W-1:0] out_src
);

    logic [31:1]            ctrl_bits;
    logic [`MLP_DATA_W-1:0] data_reg;
    logic [31:0]            instr_reg;
    logic [`MLP_DATA_W-1:0] result_reg;
    logic [`MLP_DEST_W-1:0] result_src;
    logic                   ready_flag;
    logic                   wr_en;
    logic                   rd_en;
    logic                   req_fire;
    logic                   ctrl_wr;
    logic                   result_rd;
    pkt_type_e              wr_type;

    assign wr_en    = chipselect && write;
    assign rd_en    = chipselect && read;
    assign req_fire = req_valid && req_ready;
    assign wr_type  = pkt_type_e'(writedata[6:5]);

    // A pending packet locks the control register until it is taken
    assign ctrl_wr = wr_en && (reg_addr_e'(address) == REG_CONTROL) &&
                     (!req_valid || req_ready);

    assign result_rd = rd_en && (address >= REG_RESULT0) && (address <= REG_RESULT3);

    // Send bit doubles as the request valid
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            req_valid <= 1'b0;
            ctrl_bits <= '0;
        end else begin
            if (req_fire)
                req_valid <= 1'b0;
            if (ctrl_wr) begin
                ctrl_bits <= writedata[31:1];
                req_valid <= writedata[0];
            end
        end
    end

    // Packet payload captured with the send
    always_ff @(posedge clk) begin
        if (ctrl_wr && writedata[0]) begin
            req_dest <= writedata[4:1];
            req_type <= wr_type;
            if (wr_type == PKT_INSTR)
                req_data <= {{(`MLP_DATA_W-32){1'b0}}, instr_reg};
            else
                req_data <= data_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            data_reg  <= '0;
            instr_reg <= '0;
        end else if (wr_en) begin
            case (reg_addr_e'(address))
                REG_DATA0: data_reg[31:0]   <= writedata;
                REG_DATA1: data_reg[63:32]  <= writedata;
                REG_DATA2: data_reg[95:64]  <= writedata;
                REG_DATA3: data_reg[127:96] <= writedata;
                REG_INSTR: instr_reg        <= writedata;
                default: ;
            endcase
        end
    end

    // Newest engine result
    always_ff @(posedge clk) begin
        if (out_valid)
            result_reg <= out_data;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            result_src <= '0;
            led_out    <= `MLP_LED_RESET;
        end else if (out_valid) begin
            result_src <= out_src;
            led_out    <= out_data[9:0];
        end
    end

    // A fresh result beats a clearing read
    always_ff @(posedge clk) begin
        if (!reset_n)
            ready_flag <= 1'b0;
        else if (out_valid)
            ready_flag <= 1'b1;
        else if (result_rd)
            ready_flag <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            readdata <= '0;
        end else if (rd_en) begin
            case (reg_addr_e'(address))
                REG_CONTROL: readdata <= {ctrl_bits, req_valid};
                REG_DATA0:   readdata <= data_reg[31:0];
                REG_DATA1:   readdata <= data_reg[63:32];
                REG_DATA2:   readdata <= data_reg[95:64];
                REG_DATA3:   readdata <= data_reg[127:96];
                REG_INSTR:   readdata <= instr_reg;
                REG_RESULT0: readdata <= result_reg[31:0];
                REG_RESULT1: readdata <= result_reg[63:32];
                REG_RESULT2: readdata <= result_reg[95:64];
                REG_RESULT3: readdata <= result_reg[127:96];
                REG_STATUS:  readdata <= {{(31-`MLP_DEST_W){1'b0}}, result_src, ready_flag};
                default:     readdata <= '0;
            endcase
        end
    end

endmodule

// ==== logic/mlp_macros.svh ====
`ifndef MLP_MACROS_SVH
`define MLP_MACROS_SVH

// Stream payload width, one beat per packet
`define MLP_DATA_W 128

// Destination field, wide enough for up to 16 engines
`define MLP_DEST_W 4

// Number of matrix-vector engines behind the crossbar
`define MLP_ENGINES 4

// Matrix rows, equal to the vector length
`define MLP_LANES 4

// Signed weight and vector element width
`define MLP_ELEM_W 8

// One result lane
`define MLP_ACC_W 32

// Board LEDs come up dark
`define MLP_LED_RESET 10'd0

`endif

// ==== logic/mlp_pkg.sv ====
package mlp_pkg;

    // Packet kind carried next to the stream data
    typedef enum logic [1:0] {
        PKT_INSTR  = 2'd0,
        PKT_VECTOR = 2'd1,
        PKT_WEIGHT = 2'd2
    } pkt_type_e;

    // Engine opcode in the low bits of an instruction packet
    typedef enum logic [3:0] {
        OP_NOP      = 4'd0,
        OP_MVM      = 4'd1,
        OP_MVM_RELU = 4'd2,
        OP_CLEAR    = 4'd3
    } mvm_op_e;

    // Host register map
    typedef enum logic [3:0] {
        REG_CONTROL = 4'd0,
        REG_DATA0   = 4'd1,
        REG_DATA1   = 4'd2,
        REG_DATA2   = 4'd3,
        REG_DATA3   = 4'd4,
        REG_INSTR   = 4'd5,
        REG_RESULT0 = 4'd6,
        REG_RESULT1 = 4'd7,
        REG_RESULT2 = 4'd8,
        REG_RESULT3 = 4'd9,
        REG_STATUS  = 4'd10
    } reg_addr_e;

endpackage

// ==== logic/mlp_top.sv ====
`timescale 1ns/10ps
`include "mlp_macros.svh"

module mlp_top
    import mlp_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic [3:0]  address,
    input  logic        chipselect,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic [31:0] readdata,
    output logic [9:0]  led_out
);

    // Controller to crossbar
    logic                   req_valid;
    logic                   req_ready;
    logic [`MLP_DATA_W-1:0] req_data;
    logic [`MLP_DEST_W-1:0] req_dest;
    pkt_type_e              req_type;

    // Crossbar to engines
    logic [`MLP_ENGINES-1:0]                  eng_req_valid;
    logic [`MLP_ENGINES-1:0]                  eng_req_ready;
    logic [`MLP_DATA_W-1:0]                   eng_req_data;
    pkt_type_e                                eng_req_type;
    logic [`MLP_ENGINES-1:0]                  res_valid;
    logic [`MLP_ENGINES-1:0]                  res_ready;
    logic [`MLP_ENGINES-1:0][`MLP_DATA_W-1:0] res_data;

    // Merged results back to the controller
    logic                   out_valid;
    logic [`MLP_DATA_W-1:0] out_data;
    logic [`MLP_DEST_W-1:0] out_src;

    mlp_controller u_controller (
        .clk        (clk),
        .reset_n    (reset_n),
        .address    (address),
        .chipselect (chipselect),
        .read       (read),
        .write      (write),
        .writedata  (writedata),
        .readdata   (readdata),
        .led_out    (led_out),
        .req_valid  (req_valid),
        .req_data   (req_data),
        .req_dest   (req_dest),
        .req_type   (req_type),
        .req_ready  (req_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_src    (out_src)
    );

    mvm_crossbar u_crossbar (
        .clk           (clk),
        .reset_n       (reset_n),
        .req_valid     (req_valid),
        .req_data      (req_data),
        .req_dest      (req_dest),
        .req_type      (req_type),
        .req_ready     (req_ready),
        .eng_req_valid (eng_req_valid),
        .eng_req_data  (eng_req_data),
        .eng_req_type  (eng_req_type),
        .eng_req_ready (eng_req_ready),
        .res_valid     (res_valid),
        .res_data      (res_data),
        .res_ready     (res_ready),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_src       (out_src)
    );

    for (genvar i = 0; i < `MLP_ENGINES; i++) begin : g_engine
        mvm_engine u_engine (
            .clk       (clk),
            .reset_n   (reset_n),
            .req_valid (eng_req_valid[i]),
            .req_data  (eng_req_data),
            .req_type  (eng_req_type),
            .req_ready (eng_req_ready[i]),
            .res_valid (res_valid[i]),
            .res_data  (res_data[i]),
            .res_ready (res_ready[i])
        );
    end

endmodule

// ==== logic/mvm_crossbar.sv ====
`timescale 1ns/10ps
`include "mlp_macros.svh"

module mvm_crossbar
    import mlp_pkg::*;
(
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  logic                                      req_valid,
    input  logic [`MLP_DATA_W-1:0]                    req_data,
    input  logic [`MLP_DEST_W-1:0]                    req_dest,
    input  pkt_type_e                                 req_type,
    output logic                                      req_ready,
    output logic [`MLP_ENGINES-1:0]                   eng_req_valid,
    output logic [`MLP_DATA_W-1:0]                    eng_req_data,
    output pkt_type_e                                 eng_req_type,
    input  logic [`MLP_ENGINES-1:0]                   eng_req_ready,
    input  logic [`MLP_ENGINES-1:0]                   res_valid,
    input  logic [`MLP_ENGINES-1:0][`MLP_DATA_W-1:0]  res_data,
    output logic [`MLP_ENGINES-1:0]                   res_ready,
    output logic                                      out_valid,
    output logic [`MLP_DATA_W-1:0]                    out_data,
    output logic [`MLP_DEST_W-1:0]                    out_src
);

    localparam int N = `MLP_ENGINES;

    logic [N-1:0]           grant;
    logic [`MLP_DEST_W-1:0] grant_idx;
    logic [`MLP_DEST_W-1:0] last_grant;
    logic                   found;

    // Payload fans out to every engine
    assign eng_req_data = req_data;
    assign eng_req_type = req_type;

    // Destination decode; unknown targets are swallowed
    always_comb begin
        eng_req_valid = '0;
        req_ready     = 1'b1;
        for (int i = 0; i < N; i++) begin
            if (req_dest == `MLP_DEST_W'(i)) begin
                eng_req_valid[i] = req_valid;
                req_ready        = eng_req_ready[i];
            end
        end
    end

    // Round-robin search starting just after the last winner
    always_comb begin
        int idx;
        grant     = '0;
        grant_idx = '0;
        found     = 1'b0;
        for (int k = 0; k < N; k++) begin
            idx = int'(last_grant) + 1 + k;
            if (idx >= N)
                idx = idx - N;
            if (!found && res_valid[idx]) begin
                found      = 1'b1;
                grant[idx] = 1'b1;
                grant_idx  = `MLP_DEST_W'(idx);
            end
        end
    end

    // Output register is emptied every cycle
    assign res_ready = grant;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            out_valid  <= 1'b0;
            last_grant <= `MLP_DEST_W'(N - 1);
        end else begin
            out_valid <= found;
            if (found)
                last_grant <= grant_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            out_data <= res_data[grant_idx];
            out_src  <= grant_idx;
        end
    end

endmodule

// ==== logic/mvm_engine.sv ====
`timescale 1ns/10ps
`include "mlp_macros.svh"

module mvm_engine
    import mlp_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   req_valid,
    input  logic [`MLP_DATA_W-1:0] req_data,
    input  pkt_type_e              req_type,
    output logic                   req_ready,
    output logic                   res_valid,
    output logic [`MLP_DATA_W-1:0] res_data,
    input  logic                   res_ready
);

    localparam int LANES = `MLP_LANES;
    localparam int EW    = `MLP_ELEM_W;
    localparam int AW    = `MLP_ACC_W;
    localparam int PW    = 2 * EW;

    logic signed [EW-1:0] weight [LANES][LANES];
    logic signed [EW-1:0] vec_x [LANES];
    logic signed [PW-1:0] prod [LANES][LANES];
    logic signed [AW-1:0] row_sum [LANES];
    logic signed [AW-1:0] sum_q [LANES];
    mvm_op_e              op_reg;
    mvm_op_e              req_op;
    logic                 s1_valid;
    logic                 s2_valid;
    logic                 relu1;
    logic                 relu2;
    logic                 s1_free;
    logic                 s2_free;
    logic                 s3_free;
    logic                 req_fire;
    logic                 vec_go;

    // Each stage can take new work when empty or draining
    assign s3_free   = !res_valid || res_ready;
    assign s2_free   = !s2_valid || s3_free;
    assign s1_free   = !s1_valid || s2_free;
    assign req_ready = s1_free;

    assign req_fire = req_valid && req_ready;
    assign req_op   = mvm_op_e'(req_data[3:0]);

    // Vectors under NOP are consumed without a result
    assign vec_go = req_fire && (req_type == PKT_VECTOR) &&
                    (op_reg == OP_MVM || op_reg == OP_MVM_RELU);

    always_comb begin
        for (int c = 0; c < LANES; c++)
            vec_x[c] = req_data[EW*c +: EW];
    end

    // Byte 4r+c of a weight packet is W[r][c]
    always_ff @(posedge clk) begin
        if (req_fire && req_type == PKT_WEIGHT) begin
            for (int r = 0; r < LANES; r++)
                for (int c = 0; c < LANES; c++)
                    weight[r][c] <= req_data[EW*(LANES*r+c) +: EW];
        end else if (req_fire && req_type == PKT_INSTR && req_op == OP_CLEAR) begin
            for (int r = 0; r < LANES; r++)
                for (int c = 0; c < LANES; c++)
                    weight[r][c] <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n)
            op_reg <= OP_NOP;
        else if (req_fire && req_type == PKT_INSTR) begin
            case (req_op)
                OP_MVM, OP_MVM_RELU: op_reg <= req_op;
                default:             op_reg <= OP_NOP;
            endcase
        end
    end

    // Pipeline valid bits
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            if (s1_free)
                s1_valid <= vec_go;
            if (s2_free)
                s2_valid <= s1_valid;
            if (s3_free)
                res_valid <= s2_valid;
        end
    end

    // Product stage
    always_ff @(posedge clk) begin
        if (vec_go) begin
            relu1 <= (op_reg == OP_MVM_RELU);
            for (int r = 0; r < LANES; r++)
                for (int c = 0; c < LANES; c++)
                    prod[r][c] <= weight[r][c] * vec_x[c];
        end
    end

    always_comb begin
        for (int r = 0; r < LANES; r++) begin
            row_sum[r] = '0;
            for (int c = 0; c < LANES; c++)
                row_sum[r] = row_sum[r] + prod[r][c];
        end
    end

    // Sum stage
    always_ff @(posedge clk) begin
        if (s1_valid && s2_free) begin
            relu2 <= relu1;
            for (int r = 0; r < LANES; r++)
                sum_q[r] <= row_sum[r];
        end
    end

    // Output register, negative lanes zeroed under ReLU
    always_ff @(posedge clk) begin
        if (s2_valid && s3_free) begin
            for (int r = 0; r < LANES; r++)
                res_data[AW*r +: AW] <= (relu2 && sum_q[r][AW-1]) ? '0 : sum_q[r];
        end
    end

endmodule

// ==== tests/mlp_tb.sv ====
`timescale 1ns/10ps
`include "mlp_macros.svh"

module mlp_tb
    import mlp_pkg::*;
();

    localparam int NENG      = `MLP_ENGINES;
    localparam int LANES     = `MLP_LANES;
    localparam int WAIT_MAX  = 64;
    localparam int CYCLE_MAX = 20000;

    logic        clk;
    logic        reset_n;
    logic [3:0]  address;
    logic        chipselect;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [31:0] readdata;
    logic [9:0]  led_out;

    integer seed;
    int     cycle;
    int     errors;
    int     checks;

    // Mirror of what each engine should hold
    logic signed [7:0] w_mat [NENG][LANES][LANES];
    logic signed [7:0] vec [LANES];

    // Results seen leaving the crossbar
    logic [`MLP_DATA_W-1:0] mon_data [$];
    logic [`MLP_DEST_W-1:0] mon_src [$];

    mlp_top UUT (
        .clk        (clk),
        .reset_n    (reset_n),
        .address    (address),
        .chipselect (chipselect),
        .read       (read),
        .write      (write),
        .writedata  (writedata),
        .readdata   (readdata),
        .led_out    (led_out)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_MAX) begin
            $display("Timeout: simulation ran past %0d cycles", CYCLE_MAX);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (reset_n && UUT.out_valid) begin
            mon_data.push_back(UUT.out_data);
            mon_src.push_back(UUT.out_src);
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        address    <= addr;
        writedata  <= data;
        chipselect <= 1'b1;
        write      <= 1'b1;
        @(posedge clk);
        chipselect <= 1'b0;
        write      <= 1'b0;
    endtask

    // Readdata is registered, so sample it half a cycle after the strobe edge
    task automatic bus_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clk);
        address    <= addr;
        chipselect <= 1'b1;
        read       <= 1'b1;
        @(posedge clk);
        chipselect <= 1'b0;
        read       <= 1'b0;
        @(negedge clk);
        data = readdata;
    endtask

    task automatic launch(input int dest, input pkt_type_e ptype);
        bus_write(REG_CONTROL, {25'b0, ptype, 4'(dest), 1'b1});
    endtask

    // Launch and wait for the send bit to drop
    task automatic send_packet(input int dest, input pkt_type_e ptype);
        logic [31:0] ctrl;
        int          start;
        launch(dest, ptype);
        start = cycle;
        ctrl  = 32'h1;
        while (ctrl[0] && (cycle - start) < WAIT_MAX)
            bus_read(REG_CONTROL, ctrl);
        assert (!ctrl[0])
        else begin
            errors++;
            $display("Packet to destination %0d was never accepted", dest);
        end
    endtask

    task automatic wait_result(output logic got, output logic [31:0] status);
        int start;
        start  = cycle;
        got    = 1'b0;
        status = '0;
        while (!got && (cycle - start) < WAIT_MAX) begin
            bus_read(REG_STATUS, status);
            got = status[0];
        end
    endtask

    task automatic load_weights(input int e, input bit mixed);
        int mag;
        for (int r = 0; r < LANES; r++) begin
            for (int c = 0; c < LANES; c++) begin
                mag = ($random(seed) & 63) + 1;
                if (!mixed)
                    w_mat[e][r][c] = 8'($random(seed));
                else if (r % 2 == 1)
                    w_mat[e][r][c] = 8'(-mag);
                else
                    w_mat[e][r][c] = 8'(mag);
            end
            bus_write(4'(int'(REG_DATA0) + r),
                      {w_mat[e][r][3], w_mat[e][r][2], w_mat[e][r][1], w_mat[e][r][0]});
        end
        send_packet(e, PKT_WEIGHT);
    endtask

    task automatic set_op(input int e, input mvm_op_e op);
        bus_write(REG_INSTR, {28'b0, op});
        send_packet(e, PKT_INSTR);
        if (op == OP_CLEAR) begin
            for (int r = 0; r < LANES; r++)
                for (int c = 0; c < LANES; c++)
                    w_mat[e][r][c] = '0;
        end
    endtask

    task automatic new_vector(input bit positive);
        for (int c = 0; c < LANES; c++)
            vec[c] = positive ? 8'(($random(seed) & 63) + 1) : 8'($random(seed));
        bus_write(REG_DATA0, {vec[3], vec[2], vec[1], vec[0]});
    endtask

    // Lane r is the signed dot product of row r with x, clamped under ReLU
    task automatic expected_result(input int e, input bit relu,
                                   output logic [`MLP_DATA_W-1:0] exp);
        int acc;
        for (int r = 0; r < LANES; r++) begin
            acc = 0;
            for (int c = 0; c < LANES; c++)
                acc = acc + int'(w_mat[e][r][c]) * int'(vec[c]);
            if (relu && acc < 0)
                acc = 0;
            exp[32*r +: 32] = 32'(acc);
        end
    endtask

    task automatic check_result(input int e, input bit relu);
        logic                   got;
        logic [31:0]            st;
        logic [31:0]            word;
        logic [`MLP_DATA_W-1:0] exp;
        expected_result(e, relu, exp);
        wait_result(got, st);
        assert (got)
        else begin
            errors++;
            $display("No result from engine %0d within %0d cycles", e, WAIT_MAX);
        end
        check_eq("status.ready", {31'b0, st[0]}, 32'h1);
        check_eq("status.src", {28'b0, st[4:1]}, 32'(e));
        check_eq("led_out", {22'b0, led_out}, {22'b0, exp[9:0]});
        for (int r = 0; r < LANES; r++) begin
            bus_read(4'(int'(REG_RESULT0) + r), word);
            check_eq($sformatf("RESULT%0d", r), word, exp[32*r +: 32]);
        end
        // Reading a result word drops the flag
        bus_read(REG_STATUS, st);
        check_eq("status.ready", {31'b0, st[0]}, 32'h0);
    endtask

    initial begin
        logic [31:0]            word;
        logic [31:0]            wr_val;
        logic [31:0]            st;
        logic                   got;
        logic [`MLP_DATA_W-1:0] exp;
        int                     start;

        seed       = 32'h2d6c_a70c;
        cycle      = 0;
        errors     = 0;
        checks     = 0;
        clk        = 1'b0;
        reset_n    = 1'b0;
        address    = '0;
        chipselect = 1'b0;
        read       = 1'b0;
        write      = 1'b0;
        writedata  = '0;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;

        // Register readback
        for (int k = 0; k < 5; k++) begin
            wr_val = 32'($random(seed));
            bus_write(4'(int'(REG_DATA0) + k), wr_val);
            bus_read(4'(int'(REG_DATA0) + k), word);
            check_eq($sformatf("reg[%0d]", k + 1), word, wr_val);
        end
        wr_val = 32'($random(seed)) & 32'hFFFF_FFFE;
        bus_write(REG_CONTROL, wr_val);
        bus_read(REG_CONTROL, word);
        check_eq("control", word, wr_val);
        set_op(0, OP_NOP);
        bus_read(REG_CONTROL, word);
        check_eq("control", word, {25'b0, PKT_INSTR, 4'd0, 1'b0});

        // Plain multiply
        load_weights(2, 1'b0);
        set_op(2, OP_MVM);
        new_vector(1'b0);
        send_packet(2, PKT_VECTOR);
        check_result(2, 1'b0);

        // ReLU with odd rows negative
        load_weights(1, 1'b1);
        set_op(1, OP_MVM_RELU);
        new_vector(1'b1);
        send_packet(1, PKT_VECTOR);
        check_result(1, 1'b1);

        // Routing, one engine at a time
        for (int e = 0; e < NENG; e++) begin
            load_weights(e, 1'b0);
            set_op(e, OP_MVM);
        end
        for (int e = 0; e < NENG; e++) begin
            new_vector(1'b0);
            send_packet(e, PKT_VECTOR);
            check_result(e, 1'b0);
        end

        // Burst to all engines with several vectors in flight
        new_vector(1'b0);
        mon_data.delete();
        mon_src.delete();
        for (int e = 0; e < NENG; e++)
            launch(e, PKT_VECTOR);
        start = cycle;
        while (mon_src.size() < NENG && (cycle - start) < WAIT_MAX)
            @(posedge clk);
        assert (mon_src.size() == NENG)
        else begin
            errors++;
            $display("Burst returned %0d results instead of %0d", mon_src.size(), NENG);
        end
        for (int i = 0; i < NENG && i < mon_src.size(); i++) begin
            expected_result(i, 1'b0, exp);
            check_eq("out_src", {28'b0, mon_src[i]}, 32'(i));
            for (int r = 0; r < LANES; r++)
                check_eq($sformatf("out_data[%0d]", r), mon_data[i][32*r +: 32],
                         exp[32*r +: 32]);
        end
        expected_result(NENG - 1, 1'b0, exp);
        bus_read(REG_RESULT0, word);
        check_eq("RESULT0", word, exp[31:0]);

        // Clear, then a dropped destination
        set_op(3, OP_CLEAR);
        set_op(3, OP_MVM);
        new_vector(1'b0);
        send_packet(3, PKT_VECTOR);
        check_result(3, 1'b0);
        send_packet(NENG, PKT_VECTOR);
        wait_result(got, st);
        assert (!got)
        else begin
            errors++;
            $display("Packet to missing destination %0d produced a result", NENG);
        end

        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
